// File: rtl/rv_fetch_pred_pkg.sv
`default_nettype none

package rv_fetch_pred_pkg;

  // --------------------------------------------------------------------------
  // Sizes and constants
  // --------------------------------------------------------------------------

  // Address and data width of the RV32I core
  localparam int XLEN = 32;

  // Direct-mapped BTB geometry
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W   = 4;
  // Index sits above the two byte-offset bits, tag takes the rest
  localparam int BTB_TAG_W   = XLEN - BTB_IDX_W - 2;

  // Return address stack geometry
  localparam int RAS_DEPTH = 8;
  localparam int RAS_PTR_W = 3;

  // First fetch address out of reset
  localparam logic [XLEN-1:0] RESET_PC = '0;

  // Sequential step between fetches
  localparam int INSTR_BYTES = 4;

  // --------------------------------------------------------------------------
  // Types
  // --------------------------------------------------------------------------

  typedef logic [XLEN-1:0] addr_t;

  // Control-transfer kind recorded per BTB entry
  typedef enum logic [1:0] {
    kind_branch = 2'd0,
    kind_call   = 2'd1,
    kind_return = 2'd2
  } br_kind_e;

  // Training record from execute
  typedef struct packed {
    logic     valid;
    addr_t    pc;
    addr_t    target;
    br_kind_e kind;
    logic     taken;
  } btb_update_t;

  // BTB lookup result for the current fetch PC
  typedef struct packed {
    logic     hit;
    addr_t    target;
    br_kind_e kind;
  } btb_pred_t;

  // Top of the return address stack
  typedef struct packed {
    logic  valid;
    addr_t target;
  } ras_pred_t;

  // Execute-stage correction of the fetch stream
  typedef struct packed {
    logic  valid;
    addr_t target;
  } redirect_t;

endpackage

`default_nettype wire

// File: rtl/rv_btb.sv
`timescale 1ns/10ps
`default_nettype none

module rv_btb
  import rv_fetch_pred_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  addr_t       lookup_pc,
  input  btb_update_t upd,
  output btb_pred_t   pred
);

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------

  // Valid bits are control state and clear on reset
  logic [BTB_ENTRIES-1:0] valid_q;

  // Payload arrays, only meaningful where valid_q is set
  logic [BTB_TAG_W-1:0]   tag_mem    [BTB_ENTRIES];
  addr_t                  target_mem [BTB_ENTRIES];
  br_kind_e               kind_mem   [BTB_ENTRIES];

  // Lookup side fields
  logic [BTB_IDX_W-1:0]   rd_idx;
  logic [BTB_TAG_W-1:0]   rd_tag;

  // Update side fields
  logic [BTB_IDX_W-1:0]   wr_idx;
  logic [BTB_TAG_W-1:0]   wr_tag;

  // --------------------------------------------------------------------------
  // Address split
  // --------------------------------------------------------------------------

  // Bits 1:0 are the byte offset and never take part
  assign rd_idx = lookup_pc[BTB_IDX_W+1:2];
  assign rd_tag = lookup_pc[XLEN-1:BTB_IDX_W+2];

  assign wr_idx = upd.pc[BTB_IDX_W+1:2];
  assign wr_tag = upd.pc[XLEN-1:BTB_IDX_W+2];

  // --------------------------------------------------------------------------
  // Combinational lookup
  // --------------------------------------------------------------------------

  always_comb begin
    // Hit needs a live entry with a matching tag
    pred.hit    = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    // Target and kind pass through even on a miss
    pred.target = target_mem[rd_idx];
    pred.kind   = kind_mem[rd_idx];
  end

  // --------------------------------------------------------------------------
  // Clocked update
  // --------------------------------------------------------------------------

  // Valid bits
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (upd.valid) begin
      // Taken installs the entry, not taken drops it
      valid_q[wr_idx] <= upd.taken;
    end
  end

  // Payload write, only for taken updates
  always_ff @(posedge clk) begin
    if (upd.valid && upd.taken) begin
      tag_mem[wr_idx]    <= wr_tag;
      target_mem[wr_idx] <= upd.target;
      kind_mem[wr_idx]   <= upd.kind;
    end
  end

  // New contents show up on lookups from the next cycle
  // Same-cycle lookup of the index being written sees the old entry

endmodule

`default_nettype wire

// File: rtl/rv_ras.sv
`timescale 1ns/10ps
`default_nettype none

module rv_ras
  import rv_fetch_pred_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      push,
  input  logic      pop,
  input  addr_t     push_addr,
  output ras_pred_t top
);

  // --------------------------------------------------------------------------
  // State
  // --------------------------------------------------------------------------

  // Return addresses, no reset needed
  addr_t                stack_mem [RAS_DEPTH];

  // Next free slot, wraps around the buffer
  logic [RAS_PTR_W-1:0] wr_ptr;
  // Slot holding the current top
  logic [RAS_PTR_W-1:0] top_ptr;

  // Live entries, saturates at the depth
  logic [RAS_PTR_W:0]   count;
  logic                 full;
  logic                 empty;

  assign top_ptr = wr_ptr - 1'b1;
  assign full    = (count == (RAS_PTR_W+1)'(RAS_DEPTH));
  assign empty   = (count == '0);

  // --------------------------------------------------------------------------
  // Pointer and count
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      count  <= '0;
    end else if (push && !pop) begin
      wr_ptr <= wr_ptr + 1'b1;
      // On overflow the oldest slot is reused silently
      if (!full) begin
        count <= count + 1'b1;
      end
    end else if (pop && !push && !empty) begin
      wr_ptr <= top_ptr;
      count  <= count - 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Stack write
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (push && pop) begin
      // Pop then push collapses into a top replace
      stack_mem[top_ptr] <= push_addr;
    end else if (push) begin
      stack_mem[wr_ptr] <= push_addr;
    end
  end

  // Top of stack, changes the cycle after a push or pop
  assign top.valid  = !empty;
  assign top.target = stack_mem[top_ptr];

endmodule

`default_nettype wire

// File: rtl/rv_next_pc_sel.sv
`timescale 1ns/10ps
`default_nettype none

module rv_next_pc_sel
  import rv_fetch_pred_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  redirect_t redirect,
  input  btb_pred_t btb_pred,
  input  ras_pred_t ras_top,
  input  logic      fetch_ready,
  output logic      fetch_valid,
  output addr_t     fetch_pc,
  output logic      ras_push,
  output logic      ras_pop,
  output addr_t     ras_push_addr
);

  // --------------------------------------------------------------------------
  // Local signals
  // --------------------------------------------------------------------------

  // Fetch handshake completes this cycle
  logic  accept;
  // Predictor may act on this fetch
  logic  predict_en;

  // Candidate next addresses
  addr_t pc_plus4;
  addr_t next_pc;

  // Prediction source decode
  logic  use_ras;
  logic  use_btb;
  logic  is_call;

  // --------------------------------------------------------------------------
  // Handshake
  // --------------------------------------------------------------------------

  assign accept = fetch_valid && fetch_ready;

  // Redirect wins over any prediction on the same edge
  assign predict_en = accept && !redirect.valid;

  // --------------------------------------------------------------------------
  // Source decode
  // --------------------------------------------------------------------------

  assign pc_plus4 = fetch_pc + addr_t'(INSTR_BYTES);

  // Return predicted by the stack only when it holds something
  assign use_ras = btb_pred.hit && (btb_pred.kind == kind_return) && ras_top.valid;

  // Any other hit follows the BTB target
  // Includes a return with an empty stack
  assign use_btb = btb_pred.hit && !use_ras;

  assign is_call = btb_pred.hit && (btb_pred.kind == kind_call);

  // --------------------------------------------------------------------------
  // Next PC priority mux
  // --------------------------------------------------------------------------

  always_comb begin
    next_pc = fetch_pc;
    if (redirect.valid) begin
      // Execute correction, independent of fetch_ready
      next_pc = redirect.target;
    end else if (accept) begin
      if (use_ras) begin
        next_pc = ras_top.target;
      end else if (use_btb) begin
        next_pc = btb_pred.target;
      end else begin
        next_pc = pc_plus4;
      end
    end
    // No accept and no redirect keeps the current PC
  end

  // --------------------------------------------------------------------------
  // RAS strobes
  // --------------------------------------------------------------------------

  // Both strobes qualified by an accepted, unredirected fetch
  assign ras_pop  = predict_en && use_ras;
  assign ras_push = predict_en && is_call;

  // Return address of the call being fetched
  assign ras_push_addr = pc_plus4;

  // --------------------------------------------------------------------------
  // Fetch registers
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_valid <= 1'b0;
      fetch_pc    <= RESET_PC;
    end else begin
      // Fetch stream always live once out of reset
      fetch_valid <= 1'b1;
      fetch_pc    <= next_pc;
    end
  end

endmodule

`default_nettype wire

// File: rtl/rv_fetch_pred.sv
`timescale 1ns/10ps
`default_nettype none

module rv_fetch_pred
  import rv_fetch_pred_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  redirect_t   redirect,
  input  btb_update_t btb_upd,
  input  logic        fetch_ready,
  output logic        fetch_valid,
  output addr_t       fetch_pc
);

  // --------------------------------------------------------------------------
  // Internal nets
  // --------------------------------------------------------------------------

  // BTB answer for the current fetch PC
  btb_pred_t btb_pred;

  // Stack top seen by the selector
  ras_pred_t ras_top;

  // Stack controls from the selector
  logic      ras_push;
  logic      ras_pop;
  addr_t     ras_push_addr;

  // --------------------------------------------------------------------------
  // Branch target buffer
  // --------------------------------------------------------------------------

  // Looks up the PC being offered to instruction memory
  rv_btb u_btb (
    .clk       (clk),
    .rst_n     (rst_n),
    .lookup_pc (fetch_pc),
    .upd       (btb_upd),
    .pred      (btb_pred)
  );

  // --------------------------------------------------------------------------
  // Return address stack
  // --------------------------------------------------------------------------

  rv_ras u_ras (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (ras_push),
    .pop       (ras_pop),
    .push_addr (ras_push_addr),
    .top       (ras_top)
  );

  // --------------------------------------------------------------------------
  // Next PC selection and fetch register
  // --------------------------------------------------------------------------

  rv_next_pc_sel u_sel (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect      (redirect),
    .btb_pred      (btb_pred),
    .ras_top       (ras_top),
    .fetch_ready   (fetch_ready),
    .fetch_valid   (fetch_valid),
    .fetch_pc      (fetch_pc),
    .ras_push      (ras_push),
    .ras_pop       (ras_pop),
    .ras_push_addr (ras_push_addr)
  );

endmodule

`default_nettype wire

// File: bench/rv_fetch_pred_chk.sv
`timescale 1ns/10ps
`default_nettype none

module rv_fetch_pred_chk
  import rv_fetch_pred_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input redirect_t redirect,
  input logic      fetch_ready,
  input logic      fetch_valid,
  input addr_t     fetch_pc
);

  // Failed assertions so far, watched by the testbench
  int unsigned fail_count = 0;

  // Every edge taken in reset leaves the fetch stream idle
  valid_low_in_reset: assert property (@(posedge clk) !rst_n |=> !fetch_valid)
    else begin
      fail_count++;
      $error("fetch_valid high after a reset cycle");
    end

  // Fetch addresses stay on instruction boundaries
  pc_word_aligned: assert property (
    @(posedge clk) disable iff (!rst_n) fetch_pc[1:0] == 2'b00
  ) else begin
    fail_count++;
    $error("fetch_pc 0x%08h not word aligned", fetch_pc);
  end

  // Stalled fetch keeps its address unless execute redirects
  pc_stable_on_stall: assert property (
    @(posedge clk) disable iff (!rst_n)
      (fetch_valid && !fetch_ready && !redirect.valid) |=> $stable(fetch_pc)
  ) else begin
    fail_count++;
    $error("fetch_pc moved while the fetch was stalled");
  end

endmodule

bind rv_fetch_pred rv_fetch_pred_chk u_chk (.*);

`default_nettype wire

// File: bench/rv_fetch_pred_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv_fetch_pred_tb
  import rv_fetch_pred_pkg::*;
();

  // ----------------------------------------------------------------------------
  // Run setup
  // ----------------------------------------------------------------------------

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 10;
  // Stimulus file geometry, ten hex words per cycle
  localparam int N_LINES    = 37;
  localparam int N_FIELDS   = 10;
  // Reset, every stimulus line and some slack
  localparam int TIMEOUT_CYCLES = RST_CYCLES + N_LINES + 20;

  logic        clk;
  logic        rst_n;
  redirect_t   redirect;
  btb_update_t btb_upd;
  logic        fetch_ready;
  logic        fetch_valid;
  addr_t       fetch_pc;

  logic [31:0] stim_mem [N_LINES*N_FIELDS];
  int unsigned cycle_count = 0;

  rv_fetch_pred rv_fetch_pred_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .redirect    (redirect),
    .btb_upd     (btb_upd),
    .fetch_ready (fetch_ready),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD/2) clk = ~clk;
    end
  end

  // Hard stop if the sequence stalls
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout, run still going after %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $fatal(1, "Timeout");
    end
  end

  // Bound checker failures end the run at once
  always @(negedge clk) begin
    if (rv_fetch_pred_i.u_chk.fail_count != 0) begin
      $display("Fetch handshake assertion failed in the bound checker");
      $display("** FAIL **");
      $fatal(1, "Assertion failure");
    end
  end

  // ----------------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------------

  task automatic compare_addr(input string name, input addr_t actual, input addr_t expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s = 0x%08h, expected 0x%08h",
               $time, name, actual, expected);
      $display("** FAIL **");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, actual, expected);
      $display("** FAIL **");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Read the table and reject a short or garbled file
  task automatic load_stimulus();
    $readmemh("bench/rv_fetch_pred_stim.txt", stim_mem);
    for (int k = 0; k < N_LINES*N_FIELDS; k++) begin
      if ($isunknown(stim_mem[k])) begin
        $display("Stimulus file has fewer than %0d complete lines", N_LINES);
        $display("** FAIL **");
        $fatal(1, "Bad stimulus file");
      end
    end
  endtask

  // Columns 0 to 7 are DUT inputs
  task automatic drive_line(input int line);
    int b;
    b = line * N_FIELDS;
    fetch_ready     = stim_mem[b][0];
    redirect.valid  = stim_mem[b+1][0];
    redirect.target = stim_mem[b+2];
    btb_upd.valid   = stim_mem[b+3][0];
    btb_upd.pc      = stim_mem[b+4];
    btb_upd.target  = stim_mem[b+5];
    btb_upd.kind    = br_kind_e'(stim_mem[b+6][1:0]);
    btb_upd.taken   = stim_mem[b+7][0];
  endtask

  // ----------------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------------

  initial begin
    int b;
    rst_n       = 1'b0;
    fetch_ready = 1'b0;
    redirect    = '0;
    btb_upd     = '0;
    load_stimulus();

    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Each line covers one cycle, outputs are checked mid-cycle
    for (int i = 0; i < N_LINES; i++) begin
      if (i > 0) begin
        @(negedge clk);
      end
      b = i * N_FIELDS;
      drive_line(i);
      check_flag($sformatf("fetch_valid (line %0d)", i), fetch_valid, stim_mem[b+8][0]);
      compare_addr($sformatf("fetch_pc (line %0d)", i), fetch_pc, stim_mem[b+9]);
    end

    // Let the last line reach the DUT and the checker
    @(posedge clk);
    #(CLK_PERIOD/4);
    if (rv_fetch_pred_i.u_chk.fail_count == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("Fetch handshake assertion failed in the bound checker");
      $display("** FAIL **");
      $fatal(1, "Assertion failure");
    end
  end

endmodule

`default_nettype wire

// File: rv_fetch_pred.f
rtl/rv_fetch_pred_pkg.sv
rtl/rv_btb.sv
rtl/rv_ras.sv
rtl/rv_next_pc_sel.sv
rtl/rv_fetch_pred.sv
bench/rv_fetch_pred_chk.sv
bench/rv_fetch_pred_tb.sv

// File: bench/rv_fetch_pred_stim.txt
// rdy rdr_valid rdr_target upd_valid upd_pc upd_target upd_kind upd_taken exp_valid exp_pc
// One cycle per line in hex, kind 0 branch 1 call 2 return, exp is fetch state in that cycle
1 0 00000000 1 00000018 00000080 0 1 0 00000000
1 0 00000000 0 00000000 00000000 0 0 1 00000000
0 0 00000000 1 00000100 00000100 1 1 1 00000004
0 1 00000008 1 00000208 00000310 1 1 1 00000004
0 0 00000000 1 00000310 00000314 1 1 1 00000008
1 0 00000000 1 00000314 00000500 2 1 1 00000008
1 0 00000000 1 0000020c 00000500 2 1 1 0000000c
1 0 00000000 1 00000104 00000400 2 1 1 00000010
1 0 00000000 0 00000000 00000000 0 0 1 00000014
1 0 00000000 0 00000000 00000000 0 0 1 00000018
1 1 00000018 0 00000000 00000000 0 0 1 00000080
1 1 00000040 1 00000018 00000000 0 0 1 00000018
1 1 00000018 0 00000000 00000000 0 0 1 00000040
1 0 00000000 0 00000000 00000000 0 0 1 00000018
1 1 00000100 0 00000000 00000000 0 0 1 0000001c
1 0 00000000 0 00000000 00000000 0 0 1 00000100
1 0 00000000 0 00000000 00000000 0 0 1 00000100
1 0 00000000 0 00000000 00000000 0 0 1 00000100
1 0 00000000 0 00000000 00000000 0 0 1 00000100
1 0 00000000 0 00000000 00000000 0 0 1 00000100
1 0 00000000 0 00000000 00000000 0 0 1 00000100
1 0 00000000 0 00000000 00000000 0 0 1 00000100
1 1 00000208 0 00000000 00000000 0 0 1 00000100
1 0 00000000 0 00000000 00000000 0 0 1 00000208
1 0 00000000 0 00000000 00000000 0 0 1 00000310
1 0 00000000 0 00000000 00000000 0 0 1 00000314
1 0 00000000 0 00000000 00000000 0 0 1 00000314
1 0 00000000 0 00000000 00000000 0 0 1 0000020c
1 0 00000000 0 00000000 00000000 0 0 1 00000104
0 0 00000000 0 00000000 00000000 0 0 1 00000104
1 0 00000000 0 00000000 00000000 0 0 1 00000104
1 0 00000000 0 00000000 00000000 0 0 1 00000104
1 0 00000000 0 00000000 00000000 0 0 1 00000104
1 0 00000000 0 00000000 00000000 0 0 1 00000104
1 0 00000000 0 00000000 00000000 0 0 1 00000104
1 0 00000000 0 00000000 00000000 0 0 1 00000400
1 0 00000000 0 00000000 00000000 0 0 1 00000404
